// ==== run.sh ====
#!/bin/sh
# build and run the scaler testbench with verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module scaler_tb \
    -f verilog.f \
    -Mdir obj_dir -o scaler_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/scaler_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

// ==== scaler.sv ====
// streaming video downscaler top level.
// input capture, horizontal decimation and vertical line selection with paced output.
`timescale 1ns/1ps

module scaler #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int LINE_IN_SIZE_MAX = 1024,
    parameter int SPARSE_OUT       = 2
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  scaler_pkg::step_t      reg_h_step_i,
    input  scaler_pkg::step_t      reg_v_step_i,
    input  logic [PIXEL_WIDTH-1:0] di_i,
    input  logic                   de_i,
    input  logic                   hs_i,
    input  logic                   vs_i,
    output logic [PIXEL_WIDTH-1:0] do_o,
    output logic                   de_o,
    output logic                   hs_o,
    output logic                   vs_o
);
    import scaler_pkg::*;

    // steps latched at frame start.
    scale_cfg_t cfg;

    video_if #(.PIXEL_WIDTH(PIXEL_WIDTH)) cap_if ();
    video_if #(.PIXEL_WIDTH(PIXEL_WIDTH)) hsc_if ();

    sync_capture #(
        .PIXEL_WIDTH(PIXEL_WIDTH)
    ) u_sync_capture (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .reg_h_step_i (reg_h_step_i),
        .reg_v_step_i (reg_v_step_i),
        .di_i         (di_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .out_if       (cap_if.source),
        .cfg_o        (cfg)
    );

    scaler_h #(
        .PIXEL_WIDTH(PIXEL_WIDTH)
    ) u_scaler_h (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .in_if    (cap_if.sink),
        .h_step_i (cfg.h_step),
        .out_if   (hsc_if.source)
    );

    scaler_v #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_IN_SIZE_MAX),
        .SPARSE_OUT       (SPARSE_OUT)
    ) u_scaler_v (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .in_if    (hsc_if.sink),
        .v_step_i (cfg.v_step),
        .do_o     (do_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

endmodule

// ==== scaler_h.sv ====
// horizontal nearest-neighbour decimator.
// a phase accumulator selects which input pixels of each line are kept.
`timescale 1ns/1ps

module scaler_h #(
    parameter int PIXEL_WIDTH = 12
) (
    input  logic              clk,
    input  logic              arst_n_i,
    video_if.sink             in_if,
    input  scaler_pkg::step_t h_step_i,
    video_if.source           out_if
);
    import scaler_pkg::*;

    // integer part as wide as a counter, plus the fraction.
    localparam int TGT_W = $bits(count_t) + SCALE_FRAC_BITS;

    count_t                 pix_cnt;
    logic [TGT_W-1:0]       target;
    logic                   keep;
    logic [PIXEL_WIDTH-1:0] pix_q;

    // output pixel i takes input pixel floor(i * step).
    // the step is at least 1.0, so the target never falls behind pix_cnt.
    assign keep = in_if.de && (pix_cnt == target[TGT_W-1:SCALE_FRAC_BITS]);

    // position tracking within the line.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pix_cnt <= '0;
            target  <= '0;
        end else if (in_if.hs || in_if.vs) begin
            pix_cnt <= '0;
            target  <= '0;
        end else if (in_if.de) begin
            pix_cnt <= pix_cnt + 1'b1;
            if (keep) begin
                target <= target + TGT_W'(h_step_i);
            end
        end
    end

    // strobes keep their cycle, a dropped pixel just leaves de low.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_if.de <= 1'b0;
            out_if.hs <= 1'b0;
            out_if.vs <= 1'b0;
        end else begin
            out_if.de <= keep;
            out_if.hs <= in_if.hs;
            out_if.vs <= in_if.vs;
        end
    end

    // pixel only loads on a kept position.
    always_ff @(posedge clk) begin
        if (keep) begin
            pix_q <= in_if.pix;
        end
    end

    assign out_if.pix = pix_q;

endmodule

// ==== scaler_pkg.sv ====
// shared definitions for the video downscaler.
// steps are unsigned fixed point with SCALE_FRAC_BITS fractional bits.
package scaler_pkg;

    // fractional bits of a scale step.
    localparam int SCALE_FRAC_BITS = 12;

    // 16-bit unsigned step, 4.12 fixed point.
    typedef logic [15:0] step_t;

    // pixel or line counter.
    typedef logic [15:0] count_t;

    // step value for a 1:1 ratio.
    localparam step_t SCALE_ONE = step_t'(1 << SCALE_FRAC_BITS);

    // per-frame scaling configuration.
    // values below SCALE_ONE are not supported, the scaler only shrinks.
    typedef struct packed {
        step_t h_step;
        step_t v_step;
    } scale_cfg_t;

endpackage

// ==== scaler_sva.sv ====
// assertions on the scaler output strobes.
`timescale 1ns/1ps

module scaler_sva #(
    parameter int PIXEL_WIDTH = 12,
    parameter int SPARSE_OUT  = 2
) (
    input logic                   clk,
    input logic                   arst_n_i,
    input logic [PIXEL_WIDTH-1:0] out_do_i,
    input logic                   out_de_i,
    input logic                   out_hs_i,
    input logic                   out_vs_i
);
    a_de_hs_apart: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(out_de_i && out_hs_i)) else $error("de_o and hs_o high in the same cycle");

    // each pixel is followed by SPARSE_OUT idle cycles.
    for (genvar k = 1; k <= SPARSE_OUT; k++) begin : g_gap
        a_de_gap: assert property (@(posedge clk) disable iff (!arst_n_i)
            out_de_i |-> !$past(out_de_i, k)) else $error("de_o pulses too close together");
    end

    a_strobes_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$isunknown({out_de_i, out_hs_i, out_vs_i})) else $error("output strobe unknown");

    a_pixel_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_de_i |-> !$isunknown(out_do_i)) else $error("do_o unknown while de_o is high");

endmodule

bind scaler scaler_sva #(
    .PIXEL_WIDTH (PIXEL_WIDTH),
    .SPARSE_OUT  (SPARSE_OUT)
) u_scaler_sva (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .out_do_i (do_o),
    .out_de_i (de_o),
    .out_hs_i (hs_o),
    .out_vs_i (vs_o)
);

// ==== scaler_tb.sv ====
// directed testbench for the video downscaler.
// random frames go through the DUT and are compared with a nearest-neighbour model.
`timescale 1ns/1ps

module scaler_tb;
    import scaler_pkg::*;

    localparam int PIXEL_WIDTH      = 12;
    localparam int LINE_IN_SIZE_MAX = 1024;
    localparam int SPARSE_OUT       = 2;
    localparam int FRAME_W          = 16;
    localparam int FRAME_H          = 8;
    localparam int BLANK            = 40;
    localparam int VS_CYC           = 4;
    localparam int VS_GAP           = 8;
    localparam int RESET_CYC        = 5;
    localparam int NUM_FRAMES       = 6;
    localparam int LINE_CYC         = FRAME_W + BLANK;
    localparam int WAIT_LIMIT       = 2 * LINE_CYC;
    // two extra line periods per frame cover vs lead-in and the replay tail.
    localparam int WATCHDOG_CYC = RESET_CYC + NUM_FRAMES * (FRAME_H + 2) * LINE_CYC * 12 / 10;

    logic                   clk;
    logic                   arst_n;
    step_t                  reg_h_step;
    step_t                  reg_v_step;
    logic [PIXEL_WIDTH-1:0] di;
    logic                   de_in;
    logic                   hs_in;
    logic                   vs_in;
    logic [PIXEL_WIDTH-1:0] dout;
    logic                   de_out;
    logic                   hs_out;
    logic                   vs_out;

    logic [15:0]            lfsr = 16'd23458;
    logic [PIXEL_WIDTH-1:0] in_frame [0:FRAME_H-1][0:FRAME_W-1];
    logic [PIXEL_WIDTH-1:0] out_pix [$];
    count_t                 out_len [$];
    int                     hs_cnt = 0;
    int                     vs_cnt = 0;
    int                     line_pix = 0;
    int                     gap = 0;
    logic                   in_line = 1'b0;

    tb_clock_gen #(.PERIOD_NS(100)) u_clock_gen (.clk_o(clk));

    scaler #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_IN_SIZE_MAX),
        .SPARSE_OUT       (SPARSE_OUT)
    ) u_scaler (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .reg_h_step_i (reg_h_step),
        .reg_v_step_i (reg_v_step),
        .di_i         (di),
        .de_i         (de_in),
        .hs_i         (hs_in),
        .vs_i         (vs_in),
        .do_o         (dout),
        .de_o         (de_out),
        .hs_o         (hs_out),
        .vs_o         (vs_out)
    );

    task automatic check_pixel(input string name, input logic [PIXEL_WIDTH-1:0] got,
                               input logic [PIXEL_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "pixel mismatch on %s", name);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "count mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "strobe mismatch on %s", name);
        end
    endtask

    // fibonacci lfsr, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic next_pixel(output logic [PIXEL_WIDTH-1:0] px);
        px = '0;
        for (int b = 0; b < PIXEL_WIDTH; b++) begin
            lfsr = lfsr_next(lfsr);
            px   = {px[PIXEL_WIDTH-2:0], lfsr[0]};
        end
    endtask

    // number of outputs n with floor(n * step) inside the input size.
    function automatic int kept_count(input step_t step, input int size);
        int n;
        n = 0;
        while (((n * int'(step)) >> SCALE_FRAC_BITS) < size) begin
            n++;
        end
        return n;
    endfunction

    // output monitor, also checks the replay spacing inside each line.
    always @(negedge clk) begin
        if (arst_n) begin
            if (de_out) begin
                if (in_line) begin
                    check_count("de_o spacing", count_t'(gap), count_t'(SPARSE_OUT + 1));
                end
                out_pix.push_back(dout);
                line_pix = line_pix + 1;
                in_line  = 1'b1;
                gap      = 0;
            end
            if (hs_out) begin
                check_count("hs_o delay", count_t'(gap), count_t'(SPARSE_OUT + 1));
                out_len.push_back(count_t'(line_pix));
                line_pix = 0;
                in_line  = 1'b0;
                hs_cnt   = hs_cnt + 1;
            end
            if (vs_out) begin
                vs_cnt = vs_cnt + 1;
            end
            gap = gap + 1;
        end
    end

    // steps go out with the vs edge, mid steps at the middle line.
    task automatic send_frame(input step_t h_step, input step_t v_step,
                              input step_t mid_h, input step_t mid_v);
        logic [PIXEL_WIDTH-1:0] px;
        @(posedge clk);
        reg_h_step <= h_step;
        reg_v_step <= v_step;
        vs_in      <= 1'b1;
        repeat (VS_CYC) @(posedge clk);
        vs_in <= 1'b0;
        repeat (VS_GAP) @(posedge clk);
        for (int l = 0; l < FRAME_H; l++) begin
            if (l == FRAME_H / 2) begin
                reg_h_step <= mid_h;
                reg_v_step <= mid_v;
            end
            for (int p = 0; p < FRAME_W; p++) begin
                next_pixel(px);
                in_frame[l][p] = px;
                di    <= px;
                de_in <= 1'b1;
                hs_in <= 1'b1;
                @(posedge clk);
            end
            di    <= '0;
            de_in <= 1'b0;
            hs_in <= 1'b0;
            repeat (BLANK) @(posedge clk);
        end
    endtask

    task automatic wait_lines(input int exp_lines);
        int waited;
        waited = 0;
        while (hs_cnt < exp_lines && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (hs_cnt < exp_lines) begin
            $display("output lines did not arrive in time, %0d of %0d seen", hs_cnt, exp_lines);
            $display("RESULT: FAIL");
            $fatal(1, "line wait timed out");
        end else begin
            // extra time to catch surplus lines.
            repeat (BLANK) @(posedge clk);
        end
    endtask

    task automatic check_frame(input step_t h_step, input step_t v_step);
        int exp_w;
        int exp_lines;
        int src_l;
        int src_p;
        int idx;
        exp_w     = kept_count(h_step, FRAME_W);
        exp_lines = kept_count(v_step, FRAME_H);
        idx       = 0;
        check_count("hs_o count", count_t'(hs_cnt), count_t'(exp_lines));
        check_count("vs_o count", count_t'(vs_cnt), count_t'(1));
        for (int j = 0; j < exp_lines; j++) begin
            src_l = (j * int'(v_step)) >> SCALE_FRAC_BITS;
            check_count($sformatf("line %0d length", j), out_len[j], count_t'(exp_w));
            for (int i = 0; i < exp_w; i++) begin
                src_p = (i * int'(h_step)) >> SCALE_FRAC_BITS;
                check_pixel($sformatf("do_o line %0d pixel %0d", j, i), out_pix[idx],
                            in_frame[src_l][src_p]);
                idx++;
            end
        end
        out_pix.delete();
        out_len.delete();
        hs_cnt = 0;
        vs_cnt = 0;
    endtask

    task automatic run_frame(input step_t h_step, input step_t v_step,
                             input step_t mid_h, input step_t mid_v);
        send_frame(h_step, v_step, mid_h, mid_v);
        wait_lines(kept_count(v_step, FRAME_H));
        check_frame(h_step, v_step);
    endtask

    task automatic test_identity();
        @(negedge clk);
        check_bit("de_o", de_out, 1'b0);
        check_bit("hs_o", hs_out, 1'b0);
        check_bit("vs_o", vs_out, 1'b0);
        run_frame(SCALE_ONE, SCALE_ONE, SCALE_ONE, SCALE_ONE);
    endtask

    task automatic test_h_decimate();
        run_frame(step_t'(8192), SCALE_ONE, step_t'(8192), SCALE_ONE);
    endtask

    task automatic test_v_decimate();
        run_frame(SCALE_ONE, step_t'(6144), SCALE_ONE, step_t'(6144));
    endtask

    task automatic test_both();
        run_frame(step_t'(6144), step_t'(8192), step_t'(6144), step_t'(8192));
    endtask

    // new steps in mid frame only apply from the next frame on.
    task automatic test_step_change();
        run_frame(SCALE_ONE, SCALE_ONE, step_t'(8192), step_t'(6144));
        run_frame(step_t'(8192), step_t'(6144), step_t'(8192), step_t'(6144));
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("RESULT: FAIL");
        $fatal(1, "simulation timeout");
    end

    initial begin
        arst_n     = 1'b0;
        reg_h_step = SCALE_ONE;
        reg_v_step = SCALE_ONE;
        di         = '0;
        de_in      = 1'b0;
        hs_in      = 1'b0;
        vs_in      = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        arst_n <= 1'b1;
        test_identity();
        test_h_decimate();
        test_v_decimate();
        test_both();
        test_step_change();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== scaler_v.sv ====
// vertical line selector of the scaler.
// kept lines go into a ping-pong line buffer and are replayed with idle cycles per pixel.
`timescale 1ns/1ps

module scaler_v #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int LINE_IN_SIZE_MAX = 1024,
    parameter int SPARSE_OUT       = 2
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    video_if.sink                  in_if,
    input  scaler_pkg::step_t      v_step_i,
    output logic [PIXEL_WIDTH-1:0] do_o,
    output logic                   de_o,
    output logic                   hs_o,
    output logic                   vs_o
);
    import scaler_pkg::*;

    localparam int TGT_W  = $bits(count_t) + SCALE_FRAC_BITS;
    localparam int ADDR_W = (LINE_IN_SIZE_MAX > 1) ? $clog2(LINE_IN_SIZE_MAX) : 1;
    localparam int PACE_W = (SPARSE_OUT > 0) ? $clog2(SPARSE_OUT + 1) : 1;

    // two line halves, the top address bit selects the half.
    logic [PIXEL_WIDTH-1:0] line_mem [0:2*(2**ADDR_W)-1];

    count_t            line_cnt;
    logic [TGT_W-1:0]  target;
    logic              line_keep;
    logic              wr_en;
    logic              wr_sel;
    count_t            wr_cnt;
    logic              rd_active;
    logic              rd_sel;
    count_t            rd_addr;
    count_t            rd_len;
    logic [PACE_W-1:0] pace;
    logic              rd_pix;

    // output line j takes input line floor(j * step).
    assign line_keep = (line_cnt == target[TGT_W-1:SCALE_FRAC_BITS]);
    assign wr_en     = in_if.de && line_keep && (wr_cnt < count_t'(LINE_IN_SIZE_MAX));

    // line selection and write side.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            line_cnt <= '0;
            target   <= '0;
            wr_sel   <= 1'b0;
            wr_cnt   <= '0;
        end else if (in_if.vs) begin
            line_cnt <= '0;
            target   <= '0;
            wr_cnt   <= '0;
        end else if (in_if.hs) begin
            line_cnt <= line_cnt + 1'b1;
            wr_cnt   <= '0;
            // a kept line is complete, writing moves to the other half.
            if (line_keep) begin
                target <= target + TGT_W'(v_step_i);
                wr_sel <= ~wr_sel;
            end
        end else if (wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[{wr_sel, wr_cnt[ADDR_W-1:0]}] <= in_if.pix;
        end
    end

    // a pixel goes out once the idle cycles of the previous one have run.
    assign rd_pix = rd_active && (pace == '0) && (rd_addr < rd_len);

    // replay side.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_active <= 1'b0;
            rd_sel    <= 1'b0;
            rd_addr   <= '0;
            rd_len    <= '0;
            pace      <= '0;
            de_o      <= 1'b0;
            hs_o      <= 1'b0;
            vs_o      <= 1'b0;
        end else begin
            de_o <= rd_pix;
            hs_o <= 1'b0;
            vs_o <= in_if.vs;
            if (in_if.hs && line_keep) begin
                rd_active <= 1'b1;
                rd_sel    <= wr_sel;
                rd_addr   <= '0;
                rd_len    <= wr_cnt;
                pace      <= '0;
            end else if (rd_active) begin
                if (pace != '0) begin
                    pace <= pace - 1'b1;
                end else if (rd_pix) begin
                    rd_addr <= rd_addr + 1'b1;
                    pace    <= PACE_W'(SPARSE_OUT);
                end else begin
                    // all stored pixels sent, close the line.
                    hs_o      <= 1'b1;
                    rd_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pix) begin
            do_o <= line_mem[{rd_sel, rd_addr[ADDR_W-1:0]}];
        end
    end

endmodule

// ==== sync_capture.sv ====
// input side of the scaler.
// registers the raw stream, turns sync levels into pulses and latches the steps per frame.
`timescale 1ns/1ps

module sync_capture #(
    parameter int PIXEL_WIDTH = 12
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  scaler_pkg::step_t      reg_h_step_i,
    input  scaler_pkg::step_t      reg_v_step_i,
    input  logic [PIXEL_WIDTH-1:0] di_i,
    input  logic                   de_i,
    input  logic                   hs_i,
    input  logic                   vs_i,
    video_if.source                out_if,
    output scaler_pkg::scale_cfg_t cfg_o
);
    import scaler_pkg::*;

    logic [PIXEL_WIDTH-1:0] di_q;
    logic                   de_q;
    logic [1:0]             hs_q;
    logic [1:0]             vs_q;
    logic                   line_end;
    logic                   frame_start;

    // falling hs ends a line, rising vs starts a frame.
    assign line_end    = hs_q[1] & ~hs_q[0];
    assign frame_start = ~vs_q[1] & vs_q[0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_q      <= 1'b0;
            hs_q      <= '0;
            vs_q      <= '0;
            out_if.de <= 1'b0;
            out_if.hs <= 1'b0;
            out_if.vs <= 1'b0;
            cfg_o     <= '{h_step: SCALE_ONE, v_step: SCALE_ONE};
        end else begin
            de_q      <= de_i;
            hs_q      <= {hs_q[0], hs_i};
            vs_q      <= {vs_q[0], vs_i};
            out_if.de <= de_q;
            out_if.hs <= line_end;
            out_if.vs <= frame_start;
            // new steps go out together with the vs pulse.
            if (frame_start) begin
                cfg_o <= '{h_step: reg_h_step_i, v_step: reg_v_step_i};
            end
        end
    end

    always_ff @(posedge clk) begin
        di_q       <= di_i;
        out_if.pix <= di_q;
    end

endmodule

// ==== tb_clock_gen.sv ====
// clock generator for the scaler testbench.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// ==== verilog.f ====
scaler_pkg.sv
video_if.sv
sync_capture.sv
scaler_h.sv
scaler_v.sv
scaler.sv
scaler_sva.sv
tb_clock_gen.sv
scaler_tb.sv

// ==== video_if.sv ====
// pixel stream link between the internal scaler stages.
`timescale 1ns/1ps

interface video_if #(
    parameter int PIXEL_WIDTH = 12
);
    logic [PIXEL_WIDTH-1:0] pix;
    logic                   de;
    // single-cycle pulses, hs at line end and vs at frame start.
    logic                   hs;
    logic                   vs;

    modport source (
        output pix,
        output de,
        output hs,
        output vs
    );

    modport sink (
        input  pix,
        input  de,
        input  hs,
        input  vs
    );
endinterface
